// File: Bender.yml
package:
  name: spi_master

sources:
  - include_dirs:
      - include
    files:
      - logic/spiRegPkg.sv
      - logic/spiLinkPkg.sv
      - logic/spiClockTimer.sv
      - logic/spiShifter.sv
      - logic/spiControl.sv
      - logic/spiCore.sv
      - logic/spi.sv
      - target: simulation
        files:
          - dv/spiTb.sv

// File: dv/spiTb.sv
// ************************************************************
// SPI master testbench
// host bus tasks, a slave on the link pins, a reference for
// the expected words and a checker on every readValid
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "spi_defs.svh"

module spiTb;

    import spiRegPkg::*;

    localparam int DATAWIDTH  = `SPI_DATAWIDTH;
    localparam int TRANSFERS  = 44;                 // 40 random plus 4 in the ss frame test
    localparam int CYCLELIMIT = TRANSFERS * (2 * DATAWIDTH * 4 + 40) + 200;

    logic        clk;
    logic        reset;
    logic        read;
    logic        write;
    logic [1:0]  address;
    logic [31:0] dataIn;
    logic        readValid;
    logic [31:0] dataOut;
    logic        transmitIrq;
    logic        receiveIrq;
    logic        miso;
    logic        mosi;
    logic        sclk;
    logic        ss;

    integer seed = 32'h360d_26ba;
    int     cycleCount = 0;

    // outstanding reads in issue order
    logic [31:0] expQ[$];
    bit          chkQ[$];
    regAddrE     addrQ[$];

    // link mode as last written to the config register
    logic modePol = 1'b0;
    logic modePha = 1'b0;
    logic modeDir = 1'b0;
    logic modeRxIre = 1'b0;
    logic modeTxIre = 1'b0;

    // slave model state
    logic [DATAWIDTH-1:0] slaveWire = '0;   // miso bits in line order with the first bit at msb
    logic [DATAWIDTH-1:0] capWire = '0;
    logic [DATAWIDTH-1:0] capturedQ[$];
    logic                 prevSclk = 1'b0;
    bit                   started = 1'b0;
    bit                   ssHighSeen = 1'b0;
    int                   bitIdx = 0;
    int                   leadCount = 0;

    spi #(
        .DATAWIDTH (DATAWIDTH)
    ) i_dut (
        .clk,
        .reset,
        .read,
        .write,
        .address,
        .dataIn,
        .readValid,
        .dataOut,
        .transmitIrq,
        .receiveIrq,
        .miso,
        .mosi,
        .sclk,
        .ss
    );

    always #4 clk = ~clk;

    task automatic failRun();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            failRun();
        end
    endtask

    // line order of a word for a given bit order
    function automatic logic [DATAWIDTH-1:0] expectWord(input logic [DATAWIDTH-1:0] word,
                                                         input logic msbFirst);
        logic [DATAWIDTH-1:0] reversed;
        int                   b;
        for (b = 0; b < DATAWIDTH; b++) begin
            reversed[b] = word[DATAWIDTH-1-b];
        end
        return msbFirst ? word : reversed;
    endfunction

    // reserved config bits [11:2] read back as zero
    function automatic logic [31:0] configReadback(input logic [31:0] word);
        return word & 32'hffff_f003;
    endfunction

    task automatic busWrite(input regAddrE addr, input logic [31:0] data);
        write   = 1'b1;                     // caller sits just after a falling edge
        address = addr;
        dataIn  = data;
        @(negedge clk);
        write   = 1'b0;
    endtask

    task automatic busRead(input regAddrE addr, input logic [31:0] exp, input bit chk,
                           output logic [31:0] data);
        read    = 1'b1;
        address = addr;
        expQ.push_back(exp);
        chkQ.push_back(chk);
        addrQ.push_back(addr);
        @(negedge clk);
        read = 1'b0;
        assert (readValid == 1'b0) else begin
            $display("readValid came one cycle after the read strobe, too early");
            failRun();
        end
        @(negedge clk);
        assert (readValid == 1'b1) else begin
            $display("readValid missing two cycles after the read strobe");
            failRun();
        end
        data = dataOut;
    endtask

    task automatic setConfig(input logic [15:0] cpc, input logic pol, input logic pha,
                             input logic dir, input logic ssEn, input logic rxIre,
                             input logic txIre);
        logic [31:0] word;
        logic [31:0] got;
        logic [31:0] r;
        r    = $random(seed);
        word = {cpc, pol, pha, dir, ssEn, r[9:0], rxIre, txIre};   // junk in reserved bits
        busWrite(regConfig, word);
        modePol   = pol;
        modePha   = pha;
        modeDir   = dir;
        modeRxIre = rxIre;
        modeTxIre = txIre;
        busRead(regConfig, configReadback(word), 1'b1, got);
    endtask

    // one word each way and optionally a write that must be dropped
    task automatic runTransfer(input logic [DATAWIDTH-1:0] txw, input logic [DATAWIDTH-1:0] sw,
                               input bit tryDrop);
        logic [31:0] got;
        slaveWire = sw;
        leadCount = 0;
        busWrite(regTxData, 32'(txw));
        busRead(regStatus, 32'h0, 1'b1, got);       // busy and nothing received yet
        checkValue("transmitIrq", 32'(transmitIrq), 32'h0);    // busy masks the enable
        if (tryDrop) begin
            busWrite(regTxData, 32'(~txw));         // lost while transmitReady is low
        end
        do begin
            busRead(regStatus, 32'h0, 1'b0, got);
            assert (got == 32'h0 || got == 32'h3) else begin
                $display("status flags out of step while waiting for the word");
                failRun();
            end
        end while (got[1] == 1'b0);
        checkValue("receiveIrq", 32'(receiveIrq), 32'(modeRxIre));
        checkValue("transmitIrq", 32'(transmitIrq), 32'(modeTxIre));
        busRead(regRxData, 32'(expectWord(sw, modeDir)), 1'b1, got);
        busRead(regStatus, 32'h1, 1'b1, got);       // read consumed receiveValid
        checkValue("receiveIrq", 32'(receiveIrq), 32'h0);
        checkValue("transmitIrq", 32'(transmitIrq), 32'(modeTxIre));
        busRead(regTxData, 32'(txw), 1'b1, got);
        checkValue("captured word count", capturedQ.size(), 1);
        checkValue("mosi word", 32'(capturedQ.pop_front()), 32'(expectWord(txw, modeDir)));
        checkValue("sclk pulses", leadCount, DATAWIDTH);
        checkValue("sclk idle", 32'(sclk), 32'(modePol));
    endtask

    // read checker takes one entry per readValid
    always @(negedge clk) begin
        logic [31:0] exp;
        bit          chk;
        regAddrE     a;
        if (readValid) begin
            assert (expQ.size() > 0) else begin
                $display("readValid pulsed with no read outstanding");
                failRun();
            end
            exp = expQ.pop_front();
            chk = chkQ.pop_front();
            a   = addrQ.pop_front();
            if (chk) begin
                checkValue($sformatf("dataOut[%s]", a.name()), dataOut, exp);
            end
        end
    end

    // slave changes miso on the falling clk after the sclk edge it answers
    always @(negedge clk) begin
        if (ss) begin
            ssHighSeen = 1'b1;
            bitIdx     = 0;
            started    = 1'b0;
            miso <= slaveWire[DATAWIDTH-1];
        end else if (sclk != prevSclk) begin
            if (sclk != modePol) begin              // leading edge
                leadCount++;
                started = 1'b1;
                if (modePha) begin
                    miso <= slaveWire[DATAWIDTH-1-bitIdx];
                end else begin
                    capWire = {capWire[DATAWIDTH-2:0], mosi};
                end
            end else begin                          // trailing edge
                if (modePha) begin
                    capWire = {capWire[DATAWIDTH-2:0], mosi};
                end
                bitIdx++;
                if (bitIdx == DATAWIDTH) begin
                    capturedQ.push_back(capWire);
                    bitIdx  = 0;
                    started = 1'b0;
                end else if (!modePha) begin
                    miso <= slaveWire[DATAWIDTH-1-bitIdx];
                end
            end
        end else if (!started) begin
            miso <= slaveWire[DATAWIDTH-1];         // first bit ready before the first edge
        end
        prevSclk = sclk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLELIMIT) begin
            $display("timeout after %0d cycles, a transfer never completed", cycleCount);
            $display("CHECKS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        logic [31:0] got;
        logic [31:0] r;
        logic [31:0] s;
        int          i;
        clk     = 1'b0;
        reset   = 1'b1;
        read    = 1'b0;
        write   = 1'b0;
        address = '0;
        dataIn  = '0;
        miso    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state of the pins and registers
        checkValue("ss", 32'(ss), 32'h1);
        checkValue("sclk", 32'(sclk), 32'h0);
        checkValue("mosi", 32'(mosi), 32'h0);
        checkValue("transmitIrq", 32'(transmitIrq), 32'h0);
        checkValue("receiveIrq", 32'(receiveIrq), 32'h0);
        busRead(regStatus, 32'h1, 1'b1, got);
        busRead(regConfig, 32'h0, 1'b1, got);
        busWrite(regStatus, 32'hffff_ffff);         // read only so ignored
        busRead(regStatus, 32'h1, 1'b1, got);
        setConfig(16'd2, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
        busRead(regStatus, 32'h1, 1'b1, got);
        checkValue("transmitIrq", 32'(transmitIrq), 32'h1);

        // all modes, both bit orders and half periods 0 to 3
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            setConfig(16'((i / 8) % 4), i[0], i[1], i[2], 1'b0, r[0], r[1]);
            r = $random(seed);
            s = $random(seed);
            runTransfer(r[DATAWIDTH-1:0], s[DATAWIDTH-1:0], (i % 5) == 3);
        end

        // ss pulses between words when not framed
        setConfig(16'd1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        r = $random(seed);
        s = $random(seed);
        runTransfer(r[DATAWIDTH-1:0], s[DATAWIDTH-1:0], 1'b0);
        checkValue("ss between words", 32'(ss), 32'h1);
        r = $random(seed);
        s = $random(seed);
        runTransfer(r[DATAWIDTH-1:0], s[DATAWIDTH-1:0], 1'b0);

        // framed with the same polarity so sclk stays put while ss falls
        setConfig(16'd1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        ssHighSeen = 1'b0;
        r = $random(seed);
        s = $random(seed);
        runTransfer(r[DATAWIDTH-1:0], s[DATAWIDTH-1:0], 1'b0);
        r = $random(seed);
        s = $random(seed);
        runTransfer(r[DATAWIDTH-1:0], s[DATAWIDTH-1:0], 1'b0);
        checkValue("ss high inside frame", 32'(ssHighSeen), 32'h0);
        setConfig(16'd1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        checkValue("ss after frame", 32'(ss), 32'h1);

        @(negedge clk);                             // let the checker drain the last read
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/spi_defs.svh
// ************************************************************
// SPI master widths
// transfer word width, host bus width and register address
// width, shared by the RTL and the testbench
// ************************************************************

`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// bits per SPI transfer, 16 and 32 also work
`define SPI_DATAWIDTH 8

// host data bus
`define SPI_BUSWIDTH 32

// four registers
`define SPI_ADDRWIDTH 2

`endif

// File: logic/spi.sv
// ************************************************************
// SPI master, host register interface
// registers the bus strobes, decodes writes into load enables,
// muxes the four registers onto dataOut one cycle later and
// wraps the link core
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "spi_defs.svh"

module spi #(
    parameter int DATAWIDTH = `SPI_DATAWIDTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read,
    input  logic                      write,
    input  logic [`SPI_ADDRWIDTH-1:0] address,
    input  logic [`SPI_BUSWIDTH-1:0]  dataIn,

    output logic                      readValid,
    output logic [`SPI_BUSWIDTH-1:0]  dataOut,

    output logic                      transmitIrq,
    output logic                      receiveIrq,

    input  logic                      miso,
    output logic                      mosi,
    output logic                      sclk,
    output logic                      ss
);

    import spiRegPkg::*;

    // registered bus inputs
    logic                     readReg;
    logic                     writeReg;
    regAddrE                  addressReg;
    logic [`SPI_BUSWIDTH-1:0] dataInReg;

    // decoded requests to the core
    logic                     txLoad;
    logic                     configLoad;
    logic                     rxReadReq;
    spiConfigT                configWord;

    // core state visible to the host
    logic [DATAWIDTH-1:0]     transmitData;
    logic [DATAWIDTH-1:0]     receiveData;
    spiConfigT                cfg;
    spiStatusT                status;

    logic [`SPI_BUSWIDTH-1:0] readMux;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readReg    <= 1'b0;
            writeReg   <= 1'b0;
            addressReg <= regTxData;
            readValid  <= 1'b0;
        end else begin
            readReg    <= read;
            writeReg   <= write;
            addressReg <= regAddrE'(address);
            readValid  <= readReg;          // fixed read latency
        end
    end

    // payload only, qualified by the strobes above
    always_ff @(posedge clk) begin
        dataInReg <= dataIn;
        dataOut   <= readMux;
    end

    always_comb begin
        txLoad     = 1'b0;
        configLoad = 1'b0;
        if (writeReg) begin
            case (addressReg)
                regTxData: txLoad = 1'b1;
                regConfig: configLoad = 1'b1;
                default: ;                  // rx data and status ignore writes
            endcase
        end
    end

    // drop reserved bits [11:2] of the config word
    assign configWord = {dataInReg[31:12], dataInReg[1:0]};

    // reading the receive word consumes it
    assign rxReadReq = readReg && (addressReg == regRxData);

    always_comb begin
        readMux = '0;                       // reserved bits read zero
        case (addressReg)
            regTxData: readMux[DATAWIDTH-1:0] = transmitData;
            regRxData: readMux[DATAWIDTH-1:0] = receiveData;
            regStatus: readMux[1:0] = status;
            regConfig: begin
                readMux[31:16] = cfg.clocksPerCycle;
                readMux[15]    = cfg.clockPolarity;
                readMux[14]    = cfg.clockPhase;
                readMux[13]    = cfg.dataDirection;
                readMux[12]    = cfg.ssEnable;
                readMux[1]     = cfg.receiveIre;
                readMux[0]     = cfg.transmitIre;
            end
            default: ;
        endcase
    end

    spiCore #(
        .DATAWIDTH (DATAWIDTH)
    ) i_core (
        .clk,
        .reset,
        .txWord       (dataInReg[DATAWIDTH-1:0]),
        .configWord,
        .txLoad,
        .configLoad,
        .rxReadReq,
        .transmitData,
        .receiveData,
        .cfg,
        .status,
        .transmitIrq,
        .receiveIrq,
        .miso,
        .mosi,
        .sclk,
        .ss
    );

endmodule

`default_nettype wire

// File: logic/spiClockTimer.sv
// ************************************************************
// SPI half period timer
// reloading down counter, one tick every halfPeriod+1 clocks
// while run is high
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

module spiClockTimer (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic [15:0] halfPeriod,     // clocks per half period minus one
    output logic        tick
);

    logic [15:0] count;

    // tick on the terminal count only
    assign tick = run & (count == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!run || (count == '0)) begin
            count <= halfPeriod;            // idle preload, or start the next half period
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/spiControl.sv
// ************************************************************
// SPI link FSM
// steps lead and trail half periods per bit, drives sclk and
// ss, and strobes the shifter by clock phase
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "spi_defs.svh"

module spiControl #(
    parameter int DATAWIDTH = `SPI_DATAWIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  tick,
    input  spiRegPkg::spiConfigT  cfg,
    output spiLinkPkg::shiftCtrlT shiftCtrl,
    output logic                  timerRun,
    output logic                  done,
    output logic                  sclk,
    output logic                  ss
);

    import spiLinkPkg::*;

    localparam int COUNTWIDTH = (DATAWIDTH > 1) ? $clog2(DATAWIDTH) : 1;

    linkStateE             state;
    linkStateE             stateNext;
    logic [COUNTWIDTH-1:0] bitCount;    // bits completed so far
    logic                  pending;     // start seen during stFinish
    logic                  go;
    logic                  leadTick;
    logic                  trailTick;
    logic                  lastBit;

    assign go        = start | pending;
    assign leadTick  = (state == stLead) & tick;
    assign trailTick = (state == stTrail) & tick;
    assign lastBit   = (bitCount == COUNTWIDTH'(DATAWIDTH - 1));

    // stFinish also runs the timer, it holds ss low one more half period
    assign timerRun = (state == stLead) || (state == stTrail) || (state == stFinish);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:   if (go) stateNext = stLead;
            stLead:   if (tick) stateNext = stTrail;
            stTrail:  if (tick) stateNext = lastBit ? stFinish : stLead;
            stFinish: if (tick) stateNext = stIdle;
            default:  stateNext = stIdle;
        endcase
    end

    always_comb begin
        shiftCtrl.load = (state == stIdle) & go;
        if (cfg.clockPhase) begin
            shiftCtrl.shift  = leadTick & (bitCount != '0);  // first bit already on mosi
            shiftCtrl.sample = trailTick;
        end else begin
            shiftCtrl.sample = leadTick;
            shiftCtrl.shift  = trailTick;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= stIdle;
            bitCount <= '0;
            pending  <= 1'b0;
            done     <= 1'b0;
            sclk     <= 1'b0;
            ss       <= 1'b1;
        end else begin
            state <= stateNext;
            done  <= trailTick & lastBit;   // lands after the final edge
            ss    <= ~(cfg.ssEnable | (stateNext != stIdle));
            if (state == stIdle) begin
                bitCount <= '0;
                sclk     <= cfg.clockPolarity;  // park at idle level
            end else if (leadTick) begin
                sclk <= ~cfg.clockPolarity;
            end else if (trailTick) begin
                sclk     <= cfg.clockPolarity;
                bitCount <= bitCount + 1'b1;
            end
            if (state == stIdle) begin
                pending <= 1'b0;
            end else if (start) begin
                pending <= 1'b1;            // next word queued behind the ss hold
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/spiCore.sv
// ************************************************************
// SPI core
// config, transmit, receive and status registers with the
// interrupt outputs, around the link FSM, the half period
// timer and the shift registers
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "spi_defs.svh"

module spiCore #(
    parameter int DATAWIDTH = `SPI_DATAWIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [DATAWIDTH-1:0]  txWord,
    input  spiRegPkg::spiConfigT  configWord,
    input  logic                  txLoad,
    input  logic                  configLoad,
    input  logic                  rxReadReq,
    output logic [DATAWIDTH-1:0]  transmitData,
    output logic [DATAWIDTH-1:0]  receiveData,
    output spiRegPkg::spiConfigT  cfg,
    output spiRegPkg::spiStatusT  status,
    output logic                  transmitIrq,
    output logic                  receiveIrq,
    input  logic                  miso,
    output logic                  mosi,
    output logic                  sclk,
    output logic                  ss
);

    import spiLinkPkg::*;

    shiftCtrlT            shiftCtrl;
    logic                 accept;       // tx write taken
    logic                 start;
    logic                 done;
    logic                 timerRun;
    logic                 tick;
    logic [DATAWIDTH-1:0] rxWord;

    // a tx write while busy is simply lost
    assign accept = txLoad & status.transmitReady;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg                  <= '0;
            status.receiveValid  <= 1'b0;
            status.transmitReady <= 1'b1;
            start                <= 1'b0;
            transmitIrq          <= 1'b0;
            receiveIrq           <= 1'b0;
        end else begin
            start <= accept;                // one cycle, tx word already in place
            if (configLoad) begin
                cfg <= configWord;          // link picks it up on the next half period
            end
            if (accept) begin
                status.transmitReady <= 1'b0;
            end else if (done) begin
                status.transmitReady <= 1'b1;
            end
            // fresh word wins over a read of the old one
            if (done) begin
                status.receiveValid <= 1'b1;
            end else if (rxReadReq) begin
                status.receiveValid <= 1'b0;
            end
            transmitIrq <= cfg.transmitIre & status.transmitReady;
            receiveIrq  <= cfg.receiveIre & status.receiveValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            transmitData <= txWord;
        end
        if (done) begin
            receiveData <= rxWord;          // last sample already in the shifter
        end
    end

    spiControl #(
        .DATAWIDTH (DATAWIDTH)
    ) i_control (
        .clk,
        .reset,
        .start,
        .tick,
        .cfg,
        .shiftCtrl,
        .timerRun,
        .done,
        .sclk,
        .ss
    );

    spiClockTimer i_timer (
        .clk,
        .reset,
        .run        (timerRun),
        .halfPeriod (cfg.clocksPerCycle),
        .tick
    );

    spiShifter #(
        .DATAWIDTH (DATAWIDTH)
    ) i_shifter (
        .clk,
        .reset,
        .shiftCtrl,
        .dataDirection (cfg.dataDirection),
        .loadWord      (transmitData),
        .miso,
        .mosi,
        .rxWord
    );

endmodule

`default_nettype wire

// File: logic/spiLinkPkg.sv
// ************************************************************
// SPI link side types
// link FSM states and the strobes it sends to the shifter
// ************************************************************

`default_nettype none

package spiLinkPkg;

    typedef enum logic [1:0] {
        stIdle,                 // waiting for start, sclk parked
        stLead,                 // half period ending in the leading edge
        stTrail,                // half period ending in the trailing edge
        stFinish                // ss hold after the last edge
    } linkStateE;

    typedef struct packed {
        logic load;             // take the transmit word
        logic sample;           // capture miso
        logic shift;            // advance mosi
    } shiftCtrlT;

endpackage

`default_nettype wire

// File: logic/spiRegPkg.sv
// ************************************************************
// SPI host side types
// register map addresses plus the config and status contents
// as seen by the host bus
// ************************************************************

`default_nettype none

package spiRegPkg;

    typedef enum logic [1:0] {
        regTxData = 2'd0,               // transmit word, read/write
        regRxData = 2'd1,               // receive word, read only
        regStatus = 2'd2,               // flags, read only
        regConfig = 2'd3                // link setup, read/write
    } regAddrE;

    // config word minus its ten reserved bits [11:2]
    typedef struct packed {
        logic [15:0] clocksPerCycle;    // sclk half period minus one, in clk cycles
        logic        clockPolarity;     // sclk idle level
        logic        clockPhase;        // 0 samples on leading edge
        logic        dataDirection;     // 1 msb first, 0 lsb first
        logic        ssEnable;          // force ss low, frames several words
        logic        receiveIre;
        logic        transmitIre;
    } spiConfigT;

    typedef struct packed {
        logic receiveValid;             // new word waiting in receive register
        logic transmitReady;            // link idle, next word accepted
    } spiStatusT;

endpackage

`default_nettype wire

// File: logic/spiShifter.sv
// ************************************************************
// SPI shift registers
// transmit and receive shift registers, msb or lsb first
// ************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "spi_defs.svh"

module spiShifter #(
    parameter int DATAWIDTH = `SPI_DATAWIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  spiLinkPkg::shiftCtrlT shiftCtrl,
    input  logic                  dataDirection,    // 1 msb first
    input  logic [DATAWIDTH-1:0]  loadWord,
    input  logic                  miso,
    output logic                  mosi,
    output logic [DATAWIDTH-1:0]  rxWord
);

    logic [DATAWIDTH-1:0] txShift;
    logic [DATAWIDTH-1:0] rxShift;

    // outgoing bit sits at the end chosen by direction
    assign mosi   = dataDirection ? txShift[DATAWIDTH-1] : txShift[0];
    assign rxWord = rxShift;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txShift <= '0;                  // keeps mosi low out of reset
        end else if (shiftCtrl.load) begin
            txShift <= loadWord;
        end else if (shiftCtrl.shift) begin
            if (dataDirection) begin
                txShift <= {txShift[DATAWIDTH-2:0], 1'b0};
            end else begin
                txShift <= {1'b0, txShift[DATAWIDTH-1:1]};
            end
        end
    end

    // first bit in ends up at msb or lsb to match the tx order
    always_ff @(posedge clk) begin
        if (shiftCtrl.sample) begin
            if (dataDirection) begin
                rxShift <= {rxShift[DATAWIDTH-2:0], miso};
            end else begin
                rxShift <= {miso, rxShift[DATAWIDTH-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
logic/spiRegPkg.sv
logic/spiLinkPkg.sv
logic/spiClockTimer.sv
logic/spiShifter.sv
logic/spiControl.sv
logic/spiCore.sv
logic/spi.sv
dv/spiTb.sv
